/* all.f */
rtl/trail_pkg.sv
rtl/pixel_recover.sv
rtl/frame_buffer.sv
rtl/trail_blend.sv
rtl/display_fetch.sv
rtl/trail_top.sv
sim/tb_clock.sv
sim/tb_trail_top.sv

/* rtl/display_fetch.sv */
`timescale 1ns/1ps

module display_fetch (
  input  logic               clk_pixel,
  input  logic               sys_rst,
  input  logic               rd_strobe,  // display read request
  input  trail_pkg::hcount_t rd_hcount,  // display column
  input  trail_pkg::vcount_t rd_vcount,  // display row
  input  logic               zoom,       // 2x when high
  input  logic               wr_strobe,  // write side, same as history copy
  input  trail_pkg::addr_t   wr_addr,
  input  trail_pkg::color_t  wr_color,
  output logic               pix_strobe, // fetch_latency after rd_strobe
  output trail_pkg::rgb_t    pix_rgb
);

  localparam int lat = trail_pkg::fetch_latency;

  trail_pkg::hcount_t scaled_h;
  trail_pkg::vcount_t scaled_v;
  logic               in_window;
  trail_pkg::addr_t   rot_addr;     // transposed address
  trail_pkg::addr_t   req_addr;     // registered request address
  trail_pkg::color_t  buf_color;    // display copy output
  logic [lat-1:0]     stb_pipe;     // strobe shift register
  logic [lat-2:0]     win_pipe;     // in-window flag, follows stb_pipe

  //////////////////////////////////////////////////
  // zoom, window, rotate
  //////////////////////////////////////////////////

  assign scaled_h = zoom ? (rd_hcount >> 1) : rd_hcount;
  assign scaled_v = zoom ? (rd_vcount >> 1) : rd_vcount;

  // column spans frame rows, row spans frame columns
  assign in_window = (scaled_h < trail_pkg::hcount_t'(trail_pkg::frame_h))
                  && (scaled_v < trail_pkg::vcount_t'(trail_pkg::frame_w));

  assign rot_addr = in_window ? trail_pkg::addr_t'(scaled_v)
                              + trail_pkg::addr_t'(scaled_h)
                              * trail_pkg::addr_t'(trail_pkg::frame_w)
                              : '0; // park on entry 0 outside

  always_ff @(posedge clk_pixel) begin
    req_addr <= rot_addr;
  end

  frame_buffer display_buffer_i (
    .clk_pixel (clk_pixel),
    .wr_en     (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_color),
    .rd_addr   (req_addr),
    .rd_data   (buf_color)
  );

  //////////////////////////////////////////////////
  // strobe and window tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      stb_pipe <= '0;
    end else begin
      stb_pipe <= {stb_pipe[lat-2:0], rd_strobe};
    end
  end

  always_ff @(posedge clk_pixel) begin
    win_pipe <= {win_pipe[lat-3:0], in_window};
  end

  assign pix_strobe = stb_pipe[lat-1];

  // nibble to high half of byte, black outside
  always_ff @(posedge clk_pixel) begin
    if (win_pipe[lat-2]) begin
      pix_rgb <= {buf_color[11:8], 4'h0, buf_color[7:4], 4'h0, buf_color[3:0], 4'h0};
    end else begin
      pix_rgb <= '0;
    end
  end

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
  input  logic              clk_pixel,
  input  logic              wr_en,   // write strobe
  input  trail_pkg::addr_t  wr_addr,
  input  trail_pkg::color_t wr_data,
  input  trail_pkg::addr_t  rd_addr,
  output trail_pkg::color_t rd_data  // valid one cycle after rd_addr
);

  // one full frame, black at configuration
  trail_pkg::color_t mem [trail_pkg::frame_words] = '{default: '0};

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // read first on a same-address collision
  always_ff @(posedge clk_pixel) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* rtl/pixel_recover.sv */
`timescale 1ns/1ps

module pixel_recover (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,
  input  logic                  cam_strobe,     // one pulse per pixel
  input  trail_pkg::cam_pixel_t cam_pixel,      // 5-6-5 from camera
  input  logic                  cam_frame_done, // pulse between frames
  output logic                  rec_strobe,     // stage 1 valid
  output trail_pkg::addr_t      rec_addr,       // buffer address of pixel
  output trail_pkg::color_t     rec_color       // reduced 4-4-4 color
);

  trail_pkg::hcount_t col;       // column of the next pixel
  trail_pkg::vcount_t row;       // row of the next pixel
  trail_pkg::addr_t   pix_addr;
  trail_pkg::color_t  pix_color;

  //////////////////////////////////////////////////
  // coordinate tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_pixel) begin
    if (sys_rst || cam_frame_done) begin
      col <= '0; // new frame starts top left
      row <= '0;
    end else if (cam_strobe) begin
      if (col == trail_pkg::hcount_t'(trail_pkg::frame_w - 1)) begin
        col <= '0;
        // row wraps at the bottom of the frame
        if (row == trail_pkg::vcount_t'(trail_pkg::frame_h - 1)) begin
          row <= '0;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // row major, col + 320*row
  assign pix_addr = trail_pkg::addr_t'(col)
                  + trail_pkg::addr_t'(row) * trail_pkg::addr_t'(trail_pkg::frame_w);

  // top bits of each field
  assign pix_color = {cam_pixel[15:12], cam_pixel[10:7], cam_pixel[4:1]};

  //////////////////////////////////////////////////
  // stage 1 register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      rec_strobe <= 1'b0;
    end else begin
      rec_strobe <= cam_strobe;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (cam_strobe) begin
      rec_addr  <= pix_addr;  // feeds history read directly
      rec_color <= pix_color;
    end
  end

endmodule

/* rtl/trail_blend.sv */
`timescale 1ns/1ps

module trail_blend (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,
  input  trail_pkg::threshold_t threshold,  // brightness cutoff
  input  logic                  rec_strobe, // stage 1 item
  input  trail_pkg::addr_t      rec_addr,
  input  trail_pkg::color_t     rec_color,
  input  trail_pkg::color_t     hist_color, // history read, one cycle behind rec_*
  output logic                  wr_strobe,  // write request to both buffers
  output trail_pkg::addr_t      wr_addr,
  output trail_pkg::color_t     wr_color
);

  logic                  al_strobe;  // aligned with hist_color
  trail_pkg::addr_t      al_addr;
  trail_pkg::color_t     al_color;
  trail_pkg::threshold_t brightness; // nibble sum of camera color
  trail_pkg::color_t     faded;      // history minus one per channel
  trail_pkg::color_t     blend;

  //////////////////////////////////////////////////
  // line up with the history read
  //////////////////////////////////////////////////

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      al_strobe <= 1'b0;
    end else begin
      al_strobe <= rec_strobe;
    end
  end

  always_ff @(posedge clk_pixel) begin
    al_addr  <= rec_addr;
    al_color <= rec_color;
  end

  //////////////////////////////////////////////////
  // threshold and fade
  //////////////////////////////////////////////////

  assign brightness = trail_pkg::threshold_t'(al_color[11:8])
                    + trail_pkg::threshold_t'(al_color[7:4])
                    + trail_pkg::threshold_t'(al_color[3:0]);

  // each nibble stops at zero
  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      faded[ch*4 +: 4] = (hist_color[ch*4 +: 4] == 4'h0) ? 4'h0
                                                         : hist_color[ch*4 +: 4] - 4'h1;
    end
  end

  assign blend = (brightness >= threshold) ? al_color : faded; // bright pixel wins

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      wr_strobe <= 1'b0;
    end else begin
      wr_strobe <= al_strobe;
    end
  end

  always_ff @(posedge clk_pixel) begin
    wr_addr  <= al_addr;
    wr_color <= blend;   // lands at the next edge
  end

endmodule

/* rtl/trail_pkg.sv */
package trail_pkg;

  //////////////////////////////////////////////////
  // frame geometry
  //////////////////////////////////////////////////

  localparam int frame_w     = 320;               // camera columns
  localparam int frame_h     = 240;               // camera rows
  localparam int frame_words = frame_w * frame_h; // one buffer entry per pixel

  localparam int addr_w = 17; // enough for 76800 entries

  //////////////////////////////////////////////////
  // pixel and address types
  //////////////////////////////////////////////////

  typedef logic [addr_w-1:0] addr_t;      // frame buffer address

  // raw camera pixel, r[15:11] g[10:5] b[4:0]
  typedef logic [15:0] cam_pixel_t;

  typedef logic [11:0] color_t;           // stored 4-4-4, red on top
  typedef logic [23:0] rgb_t;             // 8-8-8 display color

  typedef logic [10:0] hcount_t;          // column count
  typedef logic [9:0]  vcount_t;          // row count

  // compared against nibble sum, max 45
  typedef logic [7:0]  threshold_t;

  //////////////////////////////////////////////////
  // pipeline constants
  //////////////////////////////////////////////////

  // rd_strobe to pix_strobe
  // address reg, buffer read, output reg
  localparam int fetch_latency = 3;

endpackage

/* rtl/trail_top.sv */
`timescale 1ns/1ps

module trail_top (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,

  // camera side
  input  logic                  cam_strobe,     // one pulse per pixel
  input  trail_pkg::cam_pixel_t cam_pixel,      // 5-6-5
  input  logic                  cam_frame_done, // restart at top left
  input  trail_pkg::threshold_t threshold,      // trail brightness cutoff

  // display side
  input  logic                  rd_strobe,      // read request
  input  trail_pkg::hcount_t    rd_hcount,
  input  trail_pkg::vcount_t    rd_vcount,
  input  logic                  zoom,           // 2x zoom
  output logic                  pix_strobe,     // answer, 3 cycles later
  output trail_pkg::rgb_t       pix_rgb
);

  // stage 1, recovered pixel
  logic              rec_strobe;
  trail_pkg::addr_t  rec_addr;
  trail_pkg::color_t rec_color;

  trail_pkg::color_t hist_color; // stored history at rec_addr

  // stage 2, write-back to both copies
  logic              wr_strobe;
  trail_pkg::addr_t  wr_addr;
  trail_pkg::color_t wr_color;

  //////////////////////////////////////////////////
  // write pipeline
  //////////////////////////////////////////////////

  pixel_recover pixel_recover_i (
    .clk_pixel      (clk_pixel),
    .sys_rst        (sys_rst),
    .cam_strobe     (cam_strobe),
    .cam_pixel      (cam_pixel),
    .cam_frame_done (cam_frame_done),
    .rec_strobe     (rec_strobe),
    .rec_addr       (rec_addr),
    .rec_color      (rec_color)
  );

  // history copy, read by the filter only
  frame_buffer history_buffer_i (
    .clk_pixel (clk_pixel),
    .wr_en     (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_color),
    .rd_addr   (rec_addr),   // unregistered, data back next cycle
    .rd_data   (hist_color)
  );

  trail_blend trail_blend_i (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .threshold  (threshold),
    .rec_strobe (rec_strobe),
    .rec_addr   (rec_addr),
    .rec_color  (rec_color),
    .hist_color (hist_color),
    .wr_strobe  (wr_strobe),
    .wr_addr    (wr_addr),
    .wr_color   (wr_color)
  );

  //////////////////////////////////////////////////
  // display pipeline
  //////////////////////////////////////////////////

  // holds the display copy, same writes as history
  display_fetch display_fetch_i (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .rd_strobe  (rd_strobe),
    .rd_hcount  (rd_hcount),
    .rd_vcount  (rd_vcount),
    .zoom       (zoom),
    .wr_strobe  (wr_strobe),
    .wr_addr    (wr_addr),
    .wr_color   (wr_color),
    .pix_strobe (pix_strobe),
    .pix_rgb    (pix_rgb)
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk_pixel
);

  localparam int half_period = 10; // 20 ns period

  initial begin
    clk_pixel = 1'b0;
  end

  always #half_period clk_pixel = ~clk_pixel; // free running

endmodule

/* sim/tb_trail_top.sv */
`timescale 1ns/1ps

module tb_trail_top;

  logic                  clk_pixel;
  logic                  sys_rst;
  logic                  cam_strobe;
  trail_pkg::cam_pixel_t cam_pixel;
  logic                  cam_frame_done;
  trail_pkg::threshold_t threshold;
  logic                  rd_strobe;
  trail_pkg::hcount_t    rd_hcount;
  trail_pkg::vcount_t    rd_vcount;
  logic                  zoom;
  logic                  pix_strobe;
  trail_pkg::rgb_t       pix_rgb;

  trail_pkg::color_t model [trail_pkg::frame_words]; // expected frame contents
  int     col;    // model write position
  int     row;
  int     errors;
  integer seed;

  tb_clock clock_i (.clk_pixel(clk_pixel));

  trail_top trail_top_i (.*);

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // top bits of the 5-bit red, 6-bit green and 5-bit blue fields
  function automatic trail_pkg::color_t reduce_pixel(input trail_pkg::cam_pixel_t p);
    int r;
    int g;
    int b;
    r = (p >> 11) & 'h1f;
    g = (p >> 5) & 'h3f;
    b = p & 'h1f;
    return trail_pkg::color_t'(((r >> 1) << 8) | ((g >> 2) << 4) | (b >> 1));
  endfunction

  function automatic trail_pkg::color_t fade_color(input trail_pkg::color_t c);
    trail_pkg::color_t res;
    int n;
    res = '0;
    for (int ch = 0; ch < 3; ch++) begin
      n = (c >> (4 * ch)) & 'hf;
      if (n > 0) n = n - 1; // one step darker with a floor at 0
      res = res | (trail_pkg::color_t'(n) << (4 * ch));
    end
    return res;
  endfunction

  function automatic trail_pkg::color_t blend_pixel(input trail_pkg::color_t cam,
                                                    input trail_pkg::color_t hist,
                                                    input trail_pkg::threshold_t thr);
    int bright;
    bright = cam[11:8] + cam[7:4] + cam[3:0]; // nibble sum
    return (bright >= thr) ? cam : fade_color(hist);
  endfunction

  // zoom, window, transpose, expand
  function automatic trail_pkg::rgb_t expected_rgb(input int h, input int v, input logic z);
    trail_pkg::color_t c;
    int sh;
    int sv;
    sh = z ? h / 2 : h;
    sv = z ? v / 2 : v;
    if (sh >= trail_pkg::frame_h || sv >= trail_pkg::frame_w) return '0; // black outside
    c = model[sv + trail_pkg::frame_w * sh];
    // nibble times 16 in each byte
    return (trail_pkg::rgb_t'(c[11:8]) << 20)
         | (trail_pkg::rgb_t'(c[7:4]) << 12)
         | (trail_pkg::rgb_t'(c[3:0]) << 4);
  endfunction

  //////////////////////////////////////////////////
  // drivers and checker
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_pixel);
      cam_strobe     = 1'b0;
      cam_frame_done = 1'b0;
      rd_strobe      = 1'b0;
    end
  endtask

  // strobe stays high across back-to-back calls
  task automatic send_pixel(input trail_pkg::cam_pixel_t p);
    int addr;
    addr = col + trail_pkg::frame_w * row;
    @(negedge clk_pixel);
    cam_strobe  = 1'b1;
    cam_pixel   = p;
    model[addr] = blend_pixel(reduce_pixel(p), model[addr], threshold);
    col++;
    if (col == trail_pkg::frame_w) begin
      col = 0;
      row = (row + 1) % trail_pkg::frame_h; // wraps after the last row
    end
  endtask

  task automatic read_check(input int h, input int v, input logic z);
    int waited;
    @(negedge clk_pixel);
    rd_strobe = 1'b1;
    rd_hcount = trail_pkg::hcount_t'(h);
    rd_vcount = trail_pkg::vcount_t'(v);
    zoom      = z;
    waited    = 0;
    do begin
      @(negedge clk_pixel);
      rd_strobe = 1'b0;
      waited++;
    end while (!pix_strobe && waited < 20);
    if (!pix_strobe) begin
      errors++;
      $display("no pix_strobe within 20 cycles of read request at %0d,%0d", h, v);
    end else begin
      check_value("pix_rgb", expected_rgb(h, v, z), pix_rgb);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    repeat (20) begin
      @(negedge clk_pixel);
      check_value("pix_strobe", 0, pix_strobe);
    end
  endtask

  task automatic test_bright_frame();
    @(negedge clk_pixel);
    threshold = 8'd0; // every pixel passes
    repeat (trail_pkg::frame_words) send_pixel($random(seed));
    idle(8);          // let the last writes land
    for (int h = 0; h < trail_pkg::frame_h; h++) begin
      for (int v = 0; v < trail_pkg::frame_w; v++) begin
        read_check(h, v, 1'b0);
      end
    end
  endtask

  task automatic test_fade();
    @(negedge clk_pixel);
    threshold = 8'd255; // nothing passes so history fades
    repeat (2 * trail_pkg::frame_words) send_pixel($random(seed));
    idle(8);
    repeat (200) begin
      read_check({$random(seed)} % trail_pkg::frame_h, {$random(seed)} % trail_pkg::frame_w,
                 1'b0);
    end
  endtask

  task automatic test_zoom_window();
    int h;
    int v;
    repeat (20) begin
      h = {$random(seed)} % trail_pkg::frame_h;
      v = {$random(seed)} % trail_pkg::frame_w;
      read_check(h, v, 1'b0);
      read_check(2 * h, 2 * v, 1'b1);
      read_check(2 * h + 1, 2 * v + 1, 1'b1); // odd half drops
    end
    read_check(trail_pkg::frame_h, 0, 1'b0);  // one past the edge
    read_check(0, trail_pkg::frame_w, 1'b0);
    read_check(2 * trail_pkg::frame_h, 0, 1'b1);
    read_check(0, 2 * trail_pkg::frame_w, 1'b1);
    read_check(2047, 1023, 1'b0);
  endtask

  task automatic test_frame_restart();
    @(negedge clk_pixel);
    threshold = 8'd0;
    repeat (10) send_pixel($random(seed));
    @(negedge clk_pixel);
    cam_strobe     = 1'b0;
    cam_frame_done = 1'b1; // back to top left
    col = 0;
    row = 0;
    idle(1);
    send_pixel(16'hf81f);
    send_pixel(16'h07e0);
    send_pixel(16'hffff);
    idle(8);
    for (int v = 0; v < 3; v++) begin
      read_check(0, v, 1'b0); // rows 0..2 of display column 0
    end
  endtask

  task automatic test_latency();
    int hs [3] = '{0, 5, 239};
    int vs [3] = '{0, 100, 319};
    int t;
    int got;
    t   = 0;
    got = 0;
    while (got < 3 && t < 20) begin
      @(negedge clk_pixel);
      if (pix_strobe) begin // request got was issued at t = got
        check_value("pix_rgb", expected_rgb(hs[got], vs[got], 1'b0), pix_rgb);
        check_value("pix_strobe cycle", got + trail_pkg::fetch_latency, t);
        got++;
      end
      rd_strobe = (t < 3);
      if (t < 3) begin
        rd_hcount = trail_pkg::hcount_t'(hs[t]);
        rd_vcount = trail_pkg::vcount_t'(vs[t]);
        zoom      = 1'b0;
      end
      t++;
    end
    if (got < 3) begin
      errors++;
      $display("only %0d of 3 back-to-back requests got a pix_strobe", got);
    end
  endtask

  initial begin
    seed           = 32'hd4e8;
    errors         = 0;
    col            = 0;
    row            = 0;
    sys_rst        = 1'b1;
    cam_strobe     = 1'b0;
    cam_pixel      = '0;
    cam_frame_done = 1'b0;
    threshold      = '0;
    rd_strobe      = 1'b0;
    rd_hcount      = '0;
    rd_vcount      = '0;
    zoom           = 1'b0;
    foreach (model[i]) model[i] = '0; // buffers start black
    repeat (16) @(negedge clk_pixel);
    sys_rst = 1'b0;
    test_reset_state();
    test_bright_frame();
    test_fade();
    test_zoom_window();
    test_frame_restart();
    test_latency();
    $display("simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
